/* list.f */
io_pkg.sv
io_decode.sv
io_regs.sv
event_timer.sv
dram_recv_flags.sv
io_readback.sv
core_io_subsys.sv
tb_core_io_subsys.sv

/* Makefile */
TOOL  = verilator
FLAGS = --binary --assert
TOP   = tb_core_io_subsys
FLIST = list.f

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir

/* tb_core_io_subsys.sv */
module tb_core_io_subsys import io_pkg::*; ();

  localparam int unsigned tb_core_id = 3;

  // Strobe offsets in the I/O window
  localparam io_addr_t send_addr      = 7'h38;
  localparam io_addr_t take_addr      = 7'h39;
  localparam io_addr_t flag_clr_addr  = 7'h3A;
  localparam io_addr_t slot_addr      = 7'h3B;
  localparam io_addr_t mask_addr      = 7'h3C;
  localparam io_addr_t ack_addr       = 7'h3D;
  localparam io_addr_t timer_clr_addr = 7'h3E;

  // Cycle budget of each test, summed for the watchdog
  localparam int desc_cycles     = 120;
  localparam int slot_cycles     = 30;
  localparam int read_cycles     = 40;
  localparam int flag_cycles     = 80;
  localparam int timer_cycles    = 100;
  localparam int watchdog_cycles = 5 + desc_cycles + slot_cycles + read_cycles
                                 + flag_cycles + timer_cycles + 100;

  logic       clk;
  logic       rst;
  io_cmd_t    cmd;
  word_t      rd_data;
  logic       rd_valid;
  dword_t     in_desc;
  logic       in_desc_valid;
  logic       in_desc_taken;
  tag_t       recv_dram_tag;
  logic       recv_dram_tag_valid;
  dword_t     data_desc;
  logic       data_desc_valid;
  dword_t     dram_wr_addr;
  logic       data_desc_ready;
  slot_ptr_t  slot_wr_ptr;
  slot_addr_t slot_wr_addr;
  logic       slot_wr_valid;
  logic       slot_wr_ready;
  logic       interrupt_in;
  logic       interrupt_in_ack;
  logic       timer_irq;
  logic       ext_irq;

  int         seed = 32'hfb1731cf;
  int         errors = 0;
  int         tests = 0;
  int         cycles = 0;
  int         slot_pulses = 0;
  int         take_pulses = 0;
  int         ack_pulses = 0;
  logic [7:0] desc_model [16];
  word_t      flag_model;

  core_io_subsys #(
    .core_id (tb_core_id)
  ) core_io_subsys_inst (
    .clk                 (clk),
    .rst                 (rst),
    .cmd                 (cmd),
    .rd_data             (rd_data),
    .rd_valid            (rd_valid),
    .in_desc             (in_desc),
    .in_desc_valid       (in_desc_valid),
    .in_desc_taken       (in_desc_taken),
    .recv_dram_tag       (recv_dram_tag),
    .recv_dram_tag_valid (recv_dram_tag_valid),
    .data_desc           (data_desc),
    .data_desc_valid     (data_desc_valid),
    .dram_wr_addr        (dram_wr_addr),
    .data_desc_ready     (data_desc_ready),
    .slot_wr_ptr         (slot_wr_ptr),
    .slot_wr_addr        (slot_wr_addr),
    .slot_wr_valid       (slot_wr_valid),
    .slot_wr_ready       (slot_wr_ready),
    .interrupt_in        (interrupt_in),
    .interrupt_in_ack    (interrupt_in_ack),
    .timer_irq           (timer_irq),
    .ext_irq             (ext_irq)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
  end

  // Pulse counters, sampled mid-cycle
  always @(negedge clk) begin
    if (slot_wr_valid) begin
      slot_pulses <= slot_pulses + 1;
    end
    if (in_desc_taken) begin
      take_pulses <= take_pulses + 1;
    end
    if (interrupt_in_ack) begin
      ack_pulses <= ack_pulses + 1;
    end
  end

  task automatic report_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
      report_failure($sformatf("ERR %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_dword(input string name, input dword_t got, input dword_t exp);
    assert (got === exp) else begin
      report_failure($sformatf("ERR %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic end_test(input string name, input int start_errors);
    tests++;
    if (errors == start_errors) begin
      $display("Test %0d %s passed", tests, name);
    end else begin
      $display("Test %0d %s failed with %0d errors", tests, name, errors - start_errors);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Concurrent checks on the bus strobes and handshakes
  //////////////////////////////////////////////////////////////////////

  logic slot_cmd;
  logic take_cmd;
  logic send_cmd;
  logic read_cmd;
  logic ext_ack_cmd;

  assign slot_cmd    = cmd.valid && cmd.wr && cmd.addr == slot_addr && cmd.data[0];
  assign take_cmd    = cmd.valid && cmd.wr && cmd.addr == take_addr && cmd.data[0];
  assign send_cmd    = cmd.valid && cmd.wr && cmd.addr == send_addr && cmd.data[0];
  assign read_cmd    = cmd.valid && !cmd.wr;
  assign ext_ack_cmd = cmd.valid && cmd.wr && cmd.addr == ack_addr && cmd.data[12];

  slot_pulse_chk: assert property (@(posedge clk) disable iff (rst)
    slot_wr_valid == slot_cmd)
    else report_failure("slot_wr_valid does not follow the slot strobe");

  take_pulse_chk: assert property (@(posedge clk) disable iff (rst)
    in_desc_taken == take_cmd)
    else report_failure("in_desc_taken does not follow the take strobe");

  rd_valid_chk: assert property (@(posedge clk) disable iff (rst)
    rd_valid == $past(read_cmd))
    else report_failure("rd_valid is not one cycle after the read command");

  desc_rise_chk: assert property (@(posedge clk) disable iff (rst)
    send_cmd && !data_desc_valid |=> data_desc_valid)
    else report_failure("data_desc_valid did not rise after the send strobe");

  desc_hold_chk: assert property (@(posedge clk) disable iff (rst)
    data_desc_valid && !data_desc_ready |=>
      data_desc_valid && $stable(data_desc) && $stable(dram_wr_addr))
    else report_failure("descriptor changed or dropped while waiting for ready");

  desc_drop_chk: assert property (@(posedge clk) disable iff (rst)
    data_desc_valid && data_desc_ready |=> !data_desc_valid)
    else report_failure("data_desc_valid stayed high after a ready edge");

  ack_pulse_chk: assert property (@(posedge clk) disable iff (rst)
    interrupt_in_ack == $past(ext_ack_cmd))
    else report_failure("interrupt_in_ack is not one cycle after the ack write");

  //////////////////////////////////////////////////////////////////////
  // Bus model
  //////////////////////////////////////////////////////////////////////

  task automatic bus_cmd(input logic wr, input io_addr_t addr, input word_t data,
                         input logic [1:0] size);
    @(posedge clk);
    cmd <= '{valid: 1'b1, wr: wr, addr: addr, data: data, size: size};
    @(posedge clk);
    cmd <= '0;
  endtask

  // Byte and half data go out replicated on all lanes
  task automatic write_byte(input io_addr_t addr, input logic [7:0] b);
    bus_cmd(1'b1, addr, {4{b}}, 2'd0);
  endtask

  task automatic write_half(input io_addr_t addr, input logic [15:0] h);
    bus_cmd(1'b1, addr, {2{h}}, 2'd1);
  endtask

  task automatic write_word(input io_addr_t addr, input word_t w);
    bus_cmd(1'b1, addr, w, 2'd2);
  endtask

  task automatic read_word(input io_addr_t addr, output word_t data);
    bus_cmd(1'b0, addr, '0, 2'd2);
    @(negedge clk);
    data = rd_data;
  endtask

  // Writes the payload window and keeps the byte model in step
  task automatic desc_write(input int offs, input word_t w, input int nbytes);
    for (int i = 0; i < nbytes; i++) begin
      desc_model[offs + i] = w[i*8 +: 8];
    end
    case (nbytes)
      1:       write_byte(io_addr_t'(offs), w[7:0]);
      2:       write_half(io_addr_t'(offs), w[15:0]);
      default: write_word(io_addr_t'(offs), w);
    endcase
  endtask

  function automatic dword_t model_dword(input int base);
    dword_t v;
    for (int i = 0; i < 8; i++) begin
      v[i*8 +: 8] = desc_model[base + i];
    end
    return v;
  endfunction

  function automatic word_t int_flags_expect(input irq_mask_t m, input logic desc_v,
                                             input logic dram, input logic pend,
                                             input logic irq_in);
    word_t v;
    v = '0;
    v[15:8] = m;
    v[7] = desc_v;
    v[6] = dram;
    v[5] = pend;
    v[4] = irq_in;
    return v;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_descriptor();
    int    start;
    int    offs;
    word_t rnd;
    start = errors;
    for (int i = 0; i < 16; i += 4) begin
      rnd = $random(seed);
      desc_write(i, rnd, 4);
    end
    for (int i = 0; i < 12; i++) begin
      rnd = $random(seed);
      offs = int'(rnd[11:8]);
      if (rnd[12]) begin
        desc_write(offs, rnd, 1);
      end else begin
        desc_write(offs & 14, rnd, 2);
      end
    end
    // Bit 0 clear must not send
    write_byte(send_addr, 8'hFE);
    @(negedge clk);
    check_word("data_desc_valid", word_t'(data_desc_valid), 32'd0);
    write_byte(send_addr, 8'h01);
    @(negedge clk);
    check_word("data_desc_valid", word_t'(data_desc_valid), 32'd1);
    check_dword("data_desc", data_desc, model_dword(0));
    check_dword("dram_wr_addr", dram_wr_addr, model_dword(8));
    repeat (3) begin
      @(negedge clk);
      check_word("data_desc_valid", word_t'(data_desc_valid), 32'd1);
    end
    @(posedge clk);
    data_desc_ready <= 1'b1;
    @(posedge clk);
    data_desc_ready <= 1'b0;
    @(negedge clk);
    check_word("data_desc_valid", word_t'(data_desc_valid), 32'd0);
    end_test("descriptor", start);
  endtask

  task automatic test_slot();
    int         start;
    int         n0;
    word_t      rnd;
    logic [7:0] top;
    start = errors;
    rnd = $random(seed);
    // Slots are numbered from 1 in the top byte
    top = {5'd0, rnd[26:24]} + 8'd1;
    write_word(7'h10, {top, rnd[23:0]});
    @(negedge clk);
    check_word("slot_wr_ptr", word_t'(slot_wr_ptr), word_t'(top - 8'd1));
    check_word("slot_wr_addr", word_t'(slot_wr_addr), word_t'(rnd[15:0]));
    n0 = slot_pulses;
    write_byte(slot_addr, 8'h00);
    write_byte(slot_addr, 8'h01);
    assert (slot_pulses - n0 == 1) else begin
      report_failure($sformatf("slot_wr_valid pulsed %0d times, expected once",
                               slot_pulses - n0));
    end
    end_test("slot write", start);
  endtask

  task automatic test_readback();
    int     start;
    int     n0;
    word_t  data;
    dword_t desc;
    start = errors;
    desc = {32'($random(seed)), 32'($random(seed))};
    @(posedge clk);
    in_desc <= desc;
    in_desc_valid <= 1'b1;
    slot_wr_ready <= 1'b1;
    read_word(7'h50, data);
    check_word("rd_data", data, word_t'(tb_core_id));
    read_word(7'h4C, data);
    check_word("rd_data", data, 32'h0001_0001);
    // Ready bits swapped over so each status bit is seen on its own
    @(posedge clk);
    slot_wr_ready <= 1'b0;
    data_desc_ready <= 1'b1;
    read_word(7'h4C, data);
    check_word("rd_data", data, 32'h0000_0101);
    @(posedge clk);
    data_desc_ready <= 1'b0;
    read_word(7'h40, data);
    check_word("rd_data", data, desc[31:0]);
    read_word(7'h44, data);
    check_word("rd_data", data, desc[63:32]);
    // Step 1 after reset keeps the timer interrupt pending
    read_word(7'h5C, data);
    check_word("rd_data", data, int_flags_expect(8'h1F, 1'b1, 1'b0, 1'b1, 1'b0));
    n0 = take_pulses;
    write_byte(take_addr, 8'h01);
    assert (take_pulses - n0 == 1) else begin
      report_failure($sformatf("in_desc_taken pulsed %0d times, expected once",
                               take_pulses - n0));
    end
    end_test("readback", start);
  endtask

  task automatic test_flags();
    int    start;
    word_t rnd;
    word_t data;
    tag_t  tag;
    start = errors;
    flag_model = '0;
    for (int i = 0; i < 12; i++) begin
      rnd = $random(seed);
      case (i)
        0:       tag = 5'd0;
        1:       tag = 5'd5;
        2:       tag = 5'd9;
        default: tag = rnd[4:0];
      endcase
      @(posedge clk);
      recv_dram_tag <= tag;
      recv_dram_tag_valid <= 1'b1;
      if (tag != 5'd0) begin
        flag_model[tag] = 1'b1;
      end
    end
    @(posedge clk);
    recv_dram_tag_valid <= 1'b0;
    repeat (3) @(posedge clk);
    read_word(7'h48, data);
    check_word("rd_data", data, flag_model);
    // Clear index rides in data bits 20:16
    write_byte(flag_clr_addr, 8'd5);
    flag_model[5] = 1'b0;
    read_word(7'h48, data);
    check_word("rd_data", data, flag_model);
    check_word("ext_irq", word_t'(ext_irq), 32'd0);
    write_byte(mask_addr, 8'h5F);
    @(negedge clk);
    check_word("ext_irq", word_t'(ext_irq), word_t'(|flag_model));
    // Timer interrupt is still pending from the reset step
    read_word(7'h5C, data);
    check_word("rd_data", data, int_flags_expect(8'h5F, 1'b1, |flag_model, 1'b1, 1'b0));
    write_byte(mask_addr, 8'h1F);
    @(negedge clk);
    check_word("ext_irq", word_t'(ext_irq), 32'd0);
    end_test("dram flags", start);
  endtask

  task automatic test_timer();
    int    start;
    int    c0;
    int    c1;
    int    n0;
    int    waited;
    int    step_cycles;
    word_t rnd;
    word_t data;
    start = errors;
    write_byte(timer_clr_addr, 8'h01);
    c0 = cycles;
    rnd = $random(seed);
    repeat (int'(rnd[3:0]) + 2) @(posedge clk);
    read_word(7'h54, data);
    c1 = cycles;
    assert (data < word_t'(c1 - c0 + 2)) else begin
      report_failure($sformatf("ERR rd_data got %h expected below %h", data,
                               word_t'(c1 - c0 + 2)));
    end
    read_word(7'h58, data);
    check_word("rd_data", data, 32'd0);
    check_word("timer_irq", word_t'(timer_irq), 32'd0);
    write_byte(mask_addr, 8'h3F);
    step_cycles = int'(rnd[6:4]) + 4;
    write_word(7'h14, word_t'(step_cycles));
    @(negedge clk);
    check_word("timer_irq", word_t'(timer_irq), 32'd0);
    waited = 0;
    while (!timer_irq && waited <= step_cycles + 3) begin
      @(negedge clk);
      waited++;
    end
    assert (timer_irq) else begin
      report_failure("timer_irq did not rise within step plus 3 cycles");
    end
    write_byte(ack_addr, 8'h20);
    @(negedge clk);
    check_word("timer_irq", word_t'(timer_irq), 32'd0);
    // External interrupt passes the reset mask
    write_byte(mask_addr, 8'h1F);
    @(posedge clk);
    interrupt_in <= 1'b1;
    @(negedge clk);
    check_word("ext_irq", word_t'(ext_irq), 32'd1);
    n0 = ack_pulses;
    write_byte(ack_addr, 8'h10);
    @(posedge clk);
    assert (ack_pulses - n0 == 1) else begin
      report_failure($sformatf("interrupt_in_ack pulsed %0d times, expected once",
                               ack_pulses - n0));
    end
    interrupt_in <= 1'b0;
    @(negedge clk);
    check_word("ext_irq", word_t'(ext_irq), 32'd0);
    end_test("timer and interrupts", start);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst <= 1'b1;
    cmd <= '0;
    in_desc <= '0;
    in_desc_valid <= 1'b0;
    recv_dram_tag <= '0;
    recv_dram_tag_valid <= 1'b0;
    data_desc_ready <= 1'b0;
    slot_wr_ready <= 1'b0;
    interrupt_in <= 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    test_descriptor();
    test_slot();
    test_readback();
    test_flags();
    test_timer();
    $display("Summary: %0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles before the tests finished", watchdog_cycles);
    $display("Done: errors found");
    $finish;
  end

endmodule

/* core_io_subsys.sv */
module core_io_subsys import io_pkg::*; #(
  parameter int unsigned core_id = 0
) (
  input  logic       clk,
  input  logic       rst,

  // Core data bus, I/O window only
  input  io_cmd_t    cmd,
  output word_t      rd_data,
  output logic       rd_valid,

  input  dword_t     in_desc,
  input  logic       in_desc_valid,
  output logic       in_desc_taken,

  input  tag_t       recv_dram_tag,
  input  logic       recv_dram_tag_valid,

  output dword_t     data_desc,
  output logic       data_desc_valid,
  output dword_t     dram_wr_addr,
  input  logic       data_desc_ready,

  output slot_ptr_t  slot_wr_ptr,
  output slot_addr_t slot_wr_addr,
  output logic       slot_wr_valid,
  input  logic       slot_wr_ready,

  input  logic       interrupt_in,
  output logic       interrupt_in_ack,
  output logic       timer_irq,
  output logic       ext_irq
);

  io_wsel_t   wsel;
  io_strb_t   strb;
  io_rsel_t   rsel;
  lane_mask_t lanes;
  dword_t     wdata;
  word_t      timer_step;
  dword_t     timer_value;
  logic       timer_pending;
  word_t      flags;
  logic       dram_any;
  irq_mask_t  mask;

  io_decode io_decode_inst (
    .cmd   (cmd),
    .wsel  (wsel),
    .strb  (strb),
    .rsel  (rsel),
    .lanes (lanes),
    .wdata (wdata)
  );

  io_regs io_regs_inst (
    .clk              (clk),
    .rst              (rst),
    .wsel             (wsel),
    .strb             (strb),
    .lanes            (lanes),
    .wdata            (wdata),
    .data_desc_ready  (data_desc_ready),
    .in_desc_valid    (in_desc_valid),
    .interrupt_in     (interrupt_in),
    .timer_pending    (timer_pending),
    .dram_any         (dram_any),
    .data_desc        (data_desc),
    .data_desc_valid  (data_desc_valid),
    .dram_wr_addr     (dram_wr_addr),
    .timer_step       (timer_step),
    .slot_wr_ptr      (slot_wr_ptr),
    .slot_wr_addr     (slot_wr_addr),
    .slot_wr_valid    (slot_wr_valid),
    .in_desc_taken    (in_desc_taken),
    .mask             (mask),
    .interrupt_in_ack (interrupt_in_ack),
    .timer_irq        (timer_irq),
    .ext_irq          (ext_irq)
  );

  event_timer event_timer_inst (
    .clk           (clk),
    .rst           (rst),
    .timer_clr     (strb.timer_clr),
    .step_wr       (wsel.timer_step),
    .timer_step    (timer_step),
    .irq_ack       (strb.irq_ack),
    .wdata         (wdata[31:0]),
    .timer_value   (timer_value),
    .timer_pending (timer_pending)
  );

  dram_recv_flags dram_recv_flags_inst (
    .clk                 (clk),
    .rst                 (rst),
    .recv_dram_tag       (recv_dram_tag),
    .recv_dram_tag_valid (recv_dram_tag_valid),
    .flags_wr            (wsel.dram_flags),
    .flag_clr            (strb.flag_clr),
    .lanes               (lanes),
    .wdata               (wdata),
    .flags               (flags),
    .dram_any            (dram_any)
  );

  io_readback #(
    .core_id (core_id)
  ) io_readback_inst (
    .clk             (clk),
    .rst             (rst),
    .rsel            (rsel),
    .addr_hi         (cmd.addr[2]),
    .in_desc         (in_desc),
    .in_desc_valid   (in_desc_valid),
    .flags           (flags),
    .timer_value     (timer_value),
    .mask            (mask),
    .timer_pending   (timer_pending),
    .dram_any        (dram_any),
    .interrupt_in    (interrupt_in),
    .data_desc_ready (data_desc_ready),
    .slot_wr_ready   (slot_wr_ready),
    .rd_data         (rd_data),
    .rd_valid        (rd_valid)
  );

endmodule

/* io_readback.sv */
module io_readback import io_pkg::*; #(
  parameter int unsigned core_id = 0
) (
  input  logic      clk,
  input  logic      rst,
  input  io_rsel_t  rsel,
  input  logic      addr_hi,
  input  dword_t    in_desc,
  input  logic      in_desc_valid,
  input  word_t     flags,
  input  dword_t    timer_value,
  input  irq_mask_t mask,
  input  logic      timer_pending,
  input  logic      dram_any,
  input  logic      interrupt_in,
  input  logic      data_desc_ready,
  input  logic      slot_wr_ready,
  output word_t     rd_data,
  output logic      rd_valid
);

  word_t status_word;
  word_t int_word;

  assign status_word = {15'd0, slot_wr_ready, 7'd0, data_desc_ready, 7'd0, in_desc_valid};

  // Low nibble stays zero, error flags are not implemented
  assign int_word = {16'd0, mask, in_desc_valid, dram_any, timer_pending, interrupt_in,
                     4'd0};

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= |rsel;
    end
  end

  // Descriptor word is captured only while one is present
  always_ff @(posedge clk) begin
    if (rsel.in_desc) begin
      if (in_desc_valid) begin
        rd_data <= addr_hi ? in_desc[63:32] : in_desc[31:0];
      end
    end else if (rsel.flags) begin
      rd_data <= flags;
    end else if (rsel.status) begin
      rd_data <= status_word;
    end else if (rsel.id) begin
      rd_data <= word_t'(core_id);
    end else if (rsel.timer_lo) begin
      rd_data <= timer_value[31:0];
    end else if (rsel.timer_hi) begin
      rd_data <= timer_value[63:32];
    end else if (rsel.int_flags) begin
      rd_data <= int_word;
    end
  end

endmodule

/* dram_recv_flags.sv */
module dram_recv_flags import io_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  tag_t       recv_dram_tag,
  input  logic       recv_dram_tag_valid,
  input  logic       flags_wr,
  input  logic       flag_clr,
  input  lane_mask_t lanes,
  input  dword_t     wdata,
  output word_t      flags,
  output logic       dram_any
);

  tag_t  tag_r;
  logic  tag_valid_r;
  word_t flags_next;

  // Input stage for timing
  always_ff @(posedge clk) begin
    tag_r <= recv_dram_tag;
    if (rst) begin
      tag_valid_r <= 1'b0;
    end else begin
      tag_valid_r <= recv_dram_tag_valid;
    end
  end

  always_comb begin
    flags_next = flags;
    if (flags_wr) begin
      flags_next = merge_word(flags, wdata[31:0], lanes[3:0]);
    end
    if (flag_clr) begin
      flags_next[wdata[20:16]] = 1'b0;
    end
    // Arriving tag beats a clear of the same bit
    if (tag_valid_r) begin
      flags_next[tag_r] = 1'b1;
    end
    flags_next[0] = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else begin
      flags <= flags_next;
    end
  end

  assign dram_any = |flags;

endmodule

/* event_timer.sv */
module event_timer import io_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   timer_clr,
  input  logic   step_wr,
  input  word_t  timer_step,
  input  logic   irq_ack,
  input  word_t  wdata,
  output dword_t timer_value,
  output logic   timer_pending
);

  word_t interval;

  // Free-running cycle counter
  always_ff @(posedge clk) begin
    if (rst || timer_clr) begin
      timer_value <= '0;
    end else begin
      timer_value <= timer_value + 64'd1;
    end
  end

  // Interval counter restarts on each step write and on each hit
  always_ff @(posedge clk) begin
    if (rst || step_wr) begin
      interval      <= '0;
      timer_pending <= 1'b0;
    end else if (interval == timer_step) begin
      interval      <= '0;
      timer_pending <= 1'b1;
    end else begin
      interval <= interval + 32'd1;
      if (irq_ack && wdata[ack_timer_bit]) begin
        timer_pending <= 1'b0;
      end
    end
  end

endmodule

/* io_regs.sv */
module io_regs import io_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  io_wsel_t   wsel,
  input  io_strb_t   strb,
  input  lane_mask_t lanes,
  input  dword_t     wdata,
  input  logic       data_desc_ready,
  input  logic       in_desc_valid,
  input  logic       interrupt_in,
  input  logic       timer_pending,
  input  logic       dram_any,
  output dword_t     data_desc,
  output logic       data_desc_valid,
  output dword_t     dram_wr_addr,
  output word_t      timer_step,
  output slot_ptr_t  slot_wr_ptr,
  output slot_addr_t slot_wr_addr,
  output logic       slot_wr_valid,
  output logic       in_desc_taken,
  output irq_mask_t  mask,
  output logic       interrupt_in_ack,
  output logic       timer_irq,
  output logic       ext_irq
);

  word_t slot_info;

  //////////////////////////////////////////////////////////////////////
  // Byte-writable payload registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wsel.data_desc) begin
      data_desc <= merge_dword(data_desc, wdata, lanes);
    end
    if (wsel.dram_addr) begin
      dram_wr_addr <= merge_dword(dram_wr_addr, wdata, lanes);
    end
    // Slot info is at 0x10, so only the low four lanes can hit it
    if (wsel.slot_info) begin
      slot_info <= merge_word(slot_info, wdata[31:0], lanes[3:0]);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Control registers
  //////////////////////////////////////////////////////////////////////

  // Step lives at 0x14, in the upper half of the lane set
  always_ff @(posedge clk) begin
    if (rst) begin
      timer_step <= timer_step_rst;
    end else if (wsel.timer_step) begin
      timer_step <= merge_word(timer_step, wdata[63:32], lanes[7:4]);
    end
  end

  // Mask byte at 0x3C lands on lane 4
  always_ff @(posedge clk) begin
    if (rst) begin
      mask <= mask_rst;
    end else if (strb.mask_wr) begin
      mask <= wdata[39:32];
    end
  end

  // Held until the consumer takes it; a ready edge wins over a new send
  always_ff @(posedge clk) begin
    if (rst) begin
      data_desc_valid <= 1'b0;
    end else if (data_desc_valid && data_desc_ready) begin
      data_desc_valid <= 1'b0;
    end else if (strb.send_desc) begin
      data_desc_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      interrupt_in_ack <= 1'b0;
    end else begin
      interrupt_in_ack <= strb.irq_ack && wdata[ack_ext_bit];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Slot table and incoming descriptor handshakes
  //////////////////////////////////////////////////////////////////////

  // Software numbers slots from 1
  assign slot_wr_ptr   = slot_info[26:24] - 3'd1;
  assign slot_wr_addr  = slot_info[addr_width-1:0];
  assign slot_wr_valid = strb.slot_wr;
  assign in_desc_taken = strb.take_desc;

  // Masked interrupts toward the core
  assign timer_irq = timer_pending && mask[irq_timer_bit];
  assign ext_irq   = (interrupt_in && mask[irq_ext_bit])
                   || (dram_any && mask[irq_dram_bit])
                   || (in_desc_valid && mask[irq_desc_bit]);

endmodule

/* io_decode.sv */
module io_decode import io_pkg::*; (
  input  io_cmd_t    cmd,
  output io_wsel_t   wsel,
  output io_strb_t   strb,
  output io_rsel_t   rsel,
  output lane_mask_t lanes,
  output dword_t     wdata
);

  logic       io_wr;
  logic       io_rd;
  logic       strb_set;
  logic [3:0] word_lanes;

  assign io_wr = cmd.valid && cmd.wr;
  assign io_rd = cmd.valid && !cmd.wr;

  // Byte data is replicated on every lane, so bit 0 holds whatever byte was hit
  assign strb_set = cmd.data[0];

  //////////////////////////////////////////////////////////////////////
  // Byte lanes and write data
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    word_lanes = 4'b0000;
    if (io_wr) begin
      case (cmd.size)
        2'd0:    word_lanes = 4'b0001 << cmd.addr[1:0];
        2'd1:    word_lanes = 4'b0011 << cmd.addr[1:0];
        default: word_lanes = 4'b1111;
      endcase
    end
  end

  // Upper word of a 64-bit register sits behind address bit 2
  assign lanes = {4'd0, word_lanes} << {cmd.addr[2], 2'b00};
  assign wdata = {cmd.data, cmd.data};

  //////////////////////////////////////////////////////////////////////
  // Write enables and strobes
  //////////////////////////////////////////////////////////////////////

  assign wsel.data_desc  = io_wr && (cmd.addr[6:3] == adr_data_desc);
  assign wsel.dram_addr  = io_wr && (cmd.addr[6:3] == adr_dram_addr);
  assign wsel.slot_info  = io_wr && (cmd.addr[6:2] == adr_slot_info);
  assign wsel.timer_step = io_wr && (cmd.addr[6:2] == adr_timer_step);
  assign wsel.dram_flags = io_wr && (cmd.addr[6:2] == adr_dram_flags);

  assign strb.send_desc = io_wr && (cmd.addr == adr_send) && strb_set;
  assign strb.take_desc = io_wr && (cmd.addr == adr_take) && strb_set;
  assign strb.slot_wr   = io_wr && (cmd.addr == adr_slot) && strb_set;
  assign strb.flag_clr  = io_wr && (cmd.addr == adr_flag_clr);
  assign strb.mask_wr   = io_wr && (cmd.addr == adr_mask);
  assign strb.irq_ack   = io_wr && (cmd.addr == adr_irq_ack);
  assign strb.timer_clr = io_wr && (cmd.addr == adr_timer_clr);

  //////////////////////////////////////////////////////////////////////
  // Read selects
  //////////////////////////////////////////////////////////////////////

  assign rsel.in_desc   = io_rd && (cmd.addr[6:3] == adr_in_desc);
  assign rsel.flags     = io_rd && (cmd.addr[6:2] == adr_flags);
  assign rsel.status    = io_rd && (cmd.addr[6:2] == adr_status);
  assign rsel.id        = io_rd && (cmd.addr[6:2] == adr_id);
  assign rsel.timer_lo  = io_rd && (cmd.addr[6:2] == adr_timer_lo);
  assign rsel.timer_hi  = io_rd && (cmd.addr[6:2] == adr_timer_hi);
  assign rsel.int_flags = io_rd && (cmd.addr[6:2] == adr_int_flags);

endmodule

/* io_pkg.sv */
package io_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths that carry a meaning
  //////////////////////////////////////////////////////////////////////

  localparam int addr_width = 16;

  typedef logic [31:0]           word_t;
  typedef logic [63:0]           dword_t;
  typedef logic [6:0]            io_addr_t;
  typedef logic [7:0]            lane_mask_t;
  typedef logic [4:0]            tag_t;
  typedef logic [7:0]            irq_mask_t;
  typedef logic [2:0]            slot_ptr_t;
  typedef logic [addr_width-1:0] slot_addr_t;

  //////////////////////////////////////////////////////////////////////
  // Bus command and decoded selects
  //////////////////////////////////////////////////////////////////////

  // Size 0 byte, 1 half, 2 word
  typedef struct packed {
    logic       valid;
    logic       wr;
    io_addr_t   addr;
    word_t      data;
    logic [1:0] size;
  } io_cmd_t;

  typedef struct packed {
    logic data_desc;
    logic dram_addr;
    logic slot_info;
    logic timer_step;
    logic dram_flags;
  } io_wsel_t;

  typedef struct packed {
    logic send_desc;
    logic take_desc;
    logic slot_wr;
    logic flag_clr;
    logic mask_wr;
    logic irq_ack;
    logic timer_clr;
  } io_strb_t;

  typedef struct packed {
    logic in_desc;
    logic flags;
    logic status;
    logic id;
    logic timer_lo;
    logic timer_hi;
    logic int_flags;
  } io_rsel_t;

  //////////////////////////////////////////////////////////////////////
  // Address map, matched on addr[6:3], addr[6:2] or addr[6:0]
  //////////////////////////////////////////////////////////////////////

  localparam logic [3:0] adr_data_desc  = 4'h0;
  localparam logic [3:0] adr_dram_addr  = 4'h1;
  localparam logic [4:0] adr_slot_info  = 5'h04;
  localparam logic [4:0] adr_timer_step = 5'h05;
  localparam logic [4:0] adr_dram_flags = 5'h06;

  // One byte per strobe
  localparam io_addr_t adr_send      = 7'h38;
  localparam io_addr_t adr_take      = 7'h39;
  localparam io_addr_t adr_flag_clr  = 7'h3A;
  localparam io_addr_t adr_slot      = 7'h3B;
  localparam io_addr_t adr_mask      = 7'h3C;
  localparam io_addr_t adr_irq_ack   = 7'h3D;
  localparam io_addr_t adr_timer_clr = 7'h3E;

  localparam logic [3:0] adr_in_desc   = 4'h8;
  localparam logic [4:0] adr_flags     = 5'h12;
  localparam logic [4:0] adr_status    = 5'h13;
  localparam logic [4:0] adr_id        = 5'h14;
  localparam logic [4:0] adr_timer_lo  = 5'h15;
  localparam logic [4:0] adr_timer_hi  = 5'h16;
  localparam logic [4:0] adr_int_flags = 5'h17;

  // Reset values
  localparam irq_mask_t mask_rst       = 8'h1F;
  localparam word_t     timer_step_rst = 32'd1;

  // Interrupt mask bits and ack bits of the written word
  localparam int irq_ext_bit   = 4;
  localparam int irq_timer_bit = 5;
  localparam int irq_dram_bit  = 6;
  localparam int irq_desc_bit  = 7;
  localparam int ack_ext_bit   = 12;
  localparam int ack_timer_bit = 13;

  // Byte-lane merge of one 32-bit word
  function automatic word_t merge_word(word_t cur, word_t din, logic [3:0] be);
    word_t res;
    res = cur;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) res[i*8 +: 8] = din[i*8 +: 8];
    end
    return res;
  endfunction

  function automatic dword_t merge_dword(dword_t cur, dword_t din, lane_mask_t be);
    return {merge_word(cur[63:32], din[63:32], be[7:4]),
            merge_word(cur[31:0], din[31:0], be[3:0])};
  endfunction

endpackage
